// File: exec_core.f
+incdir+rtl
rtl/core_types_pkg.sv
rtl/core_op_pkg.sv
rtl/decoder.sv
rtl/gpr.sv
rtl/scoreboard.sv
rtl/alu.sv
rtl/mul_unit.sv
rtl/wb_arbiter.sv
rtl/exec_core.sv
tests/tb_exec_core.sv

// File: rtl/alu.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module alu
    import core_types_pkg::*;
    import core_op_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     start_i,
    input  alu_op_e  op_i,
    input  xlen_t    a_i,
    input  xlen_t    b_i,
    input  reg_idx_t rd_i,
    input  logic     take_i,
    output logic     valid_o,
    output reg_idx_t rd_o,
    output xlen_t    result_o
);

    xlen_t                       res;
    logic [$clog2(`XLEN)-1:0]    shamt;

    assign shamt = b_i[$clog2(`XLEN)-1:0];

    always_comb begin
        case (op_i)
            alu_add:    res = a_i + b_i;
            alu_sub:    res = a_i - b_i;
            alu_sll:    res = a_i << shamt;
            alu_slt:    res = {{(`XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            alu_sltu:   res = {{(`XLEN-1){1'b0}}, a_i < b_i};
            alu_xor:    res = a_i ^ b_i;
            alu_srl:    res = a_i >> shamt;
            alu_sra:    res = $signed(a_i) >>> shamt;
            alu_or:     res = a_i | b_i;
            alu_and:    res = a_i & b_i;
            alu_pass_b: res = b_i;
            default:    res = '0;
        endcase
    end

    // start wins over take so a back-to-back issue keeps valid high
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else if (start_i) begin
            valid_o <= 1'b1;
        end else if (take_i) begin
            valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            rd_o     <= rd_i;
            result_o <= res;  // held until the arbiter takes it
        end
    end

endmodule

// File: rtl/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath and register file sizes
`define XLEN      32
`define REG_NUM   32
`define REG_IDX_W 5

// one multiplier bit per iteration
`define MUL_STEPS 32

// RV32 major opcodes handled by the slice
`define OPC_LUI    7'b0110111
`define OPC_OP_IMM 7'b0010011
`define OPC_OP     7'b0110011

`define F7_MULDIV  7'b0000001  // M extension marker in funct7

`endif

// File: rtl/core_op_pkg.sv
package core_op_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b  // lui result comes straight from the immediate
    } alu_op_e;

    // order follows funct3 of the multiply group
    typedef enum logic [1:0] {op_mul, op_mulh, op_mulhsu, op_mulhu} mul_op_e;

    typedef enum logic [1:0] {unit_none, unit_alu, unit_mul} unit_e;

    typedef enum logic [1:0] {mul_idle, mul_run, mul_done} mul_state_e;

endpackage

// File: rtl/core_types_pkg.sv
`include "core_defs.svh"

package core_types_pkg;

    // one integer data word
    typedef logic [`XLEN-1:0] xlen_t;

    // index into the general purpose registers
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // raw instruction word as it arrives on the input port
    typedef logic [31:0] inst_t;

endpackage

// File: rtl/decoder.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module decoder
    import core_types_pkg::*;
    import core_op_pkg::*;
(
    input  inst_t    inst_i,
    output unit_e    unit_o,
    output alu_op_e  alu_op_o,
    output mul_op_e  mul_op_o,
    output reg_idx_t rs1_o,
    output reg_idx_t rs2_o,
    output reg_idx_t rd_o,
    output logic     use_rs1_o,
    output logic     use_rs2_o,
    output logic     use_imm_o,
    output xlen_t    imm_o,
    output logic     illegal_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // register fields sit at fixed positions
    assign rd_o  = inst_i[11:7];
    assign rs1_o = inst_i[19:15];
    assign rs2_o = inst_i[24:20];

    always_comb begin
        unit_o    = unit_alu;
        alu_op_o  = alu_add;
        mul_op_o  = op_mul;
        use_rs1_o = 1'b0;
        use_rs2_o = 1'b0;
        use_imm_o = 1'b0;
        imm_o     = '0;
        illegal_o = 1'b0;

        case (opcode)
            `OPC_LUI: begin
                alu_op_o  = alu_pass_b;
                use_imm_o = 1'b1;
                imm_o     = {inst_i[31:12], 12'b0};
            end
            `OPC_OP_IMM: begin
                use_rs1_o = 1'b1;
                use_imm_o = 1'b1;
                imm_o     = {{20{inst_i[31]}}, inst_i[31:20]};  // I-type sign extend
                case (funct3)
                    3'b000:  alu_op_o = alu_add;
                    3'b010:  alu_op_o = alu_slt;
                    3'b011:  alu_op_o = alu_sltu;
                    3'b100:  alu_op_o = alu_xor;
                    3'b110:  alu_op_o = alu_or;
                    3'b111:  alu_op_o = alu_and;
                    3'b001: begin
                        alu_op_o  = alu_sll;
                        illegal_o = (funct7 != 7'b0000000);
                    end
                    default: begin
                        // srli and srai share funct3 and bit 30 picks arithmetic
                        alu_op_o  = funct7[5] ? alu_sra : alu_srl;
                        illegal_o = ({funct7[6], funct7[4:0]} != 6'b0);
                    end
                endcase
            end
            `OPC_OP: begin
                use_rs1_o = 1'b1;
                use_rs2_o = 1'b1;
                if (funct7 == `F7_MULDIV) begin
                    unit_o    = unit_mul;
                    mul_op_o  = mul_op_e'(funct3[1:0]);
                    illegal_o = funct3[2];  // div and rem not built
                end else if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  alu_op_o = alu_add;
                        3'b001:  alu_op_o = alu_sll;
                        3'b010:  alu_op_o = alu_slt;
                        3'b011:  alu_op_o = alu_sltu;
                        3'b100:  alu_op_o = alu_xor;
                        3'b101:  alu_op_o = alu_srl;
                        3'b110:  alu_op_o = alu_or;
                        default: alu_op_o = alu_and;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    alu_op_o = alu_sub;
                end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
                    alu_op_o = alu_sra;
                end else begin
                    illegal_o = 1'b1;
                end
            end
            default: illegal_o = 1'b1;
        endcase

        // illegal words go nowhere and never wait on the scoreboard
        if (illegal_o) begin
            unit_o    = unit_none;
            use_rs1_o = 1'b0;
            use_rs2_o = 1'b0;
        end
    end

endmodule

// File: rtl/exec_core.sv
`timescale 1ns/10ps

module exec_core
    import core_types_pkg::*;
    import core_op_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     inst_valid_i,
    input  inst_t    inst_i,
    output logic     inst_ready_o,
    output logic     wb_valid_o,
    output reg_idx_t wb_rd_o,
    output xlen_t    wb_data_o,
    output logic     illegal_inst_o
);

    // decoder outputs
    unit_e    dec_unit;
    alu_op_e  dec_alu_op;
    mul_op_e  dec_mul_op;
    reg_idx_t dec_rs1;
    reg_idx_t dec_rs2;
    reg_idx_t dec_rd;
    logic     dec_use_rs1;
    logic     dec_use_rs2;
    logic     dec_use_imm;
    xlen_t    dec_imm;
    logic     dec_illegal;
    logic     dec_wr;

    xlen_t    rs1_data;
    xlen_t    rs2_data;
    xlen_t    op_b;
    logic     hazard;
    logic     accept;
    logic     alu_start;
    logic     mul_start;

    // unit results toward the arbiter
    logic     alu_valid;
    reg_idx_t alu_rd;
    xlen_t    alu_result;
    logic     alu_take;
    logic     mul_idle;
    logic     mul_valid;
    reg_idx_t mul_rd;
    xlen_t    mul_result;
    logic     mul_take;

    logic     wb_we;
    reg_idx_t wb_rd;
    xlen_t    wb_data;
    logic     illegal_q;

    decoder u_decoder (
        .inst_i   (inst_i),
        .unit_o   (dec_unit),
        .alu_op_o (dec_alu_op),
        .mul_op_o (dec_mul_op),
        .rs1_o    (dec_rs1),
        .rs2_o    (dec_rs2),
        .rd_o     (dec_rd),
        .use_rs1_o(dec_use_rs1),
        .use_rs2_o(dec_use_rs2),
        .use_imm_o(dec_use_imm),
        .imm_o    (dec_imm),
        .illegal_o(dec_illegal)
    );

    // x0 targets and illegal words leave no trace in the units
    assign dec_wr = (dec_unit != unit_none) && (dec_rd != '0);

    assign inst_ready_o = !hazard
                        && !(dec_unit == unit_mul && !mul_idle)
                        && !(alu_valid && !alu_take);  // alu result still waiting

    assign accept    = inst_valid_i && inst_ready_o;
    assign alu_start = accept && dec_wr && (dec_unit == unit_alu);
    assign mul_start = accept && dec_wr && (dec_unit == unit_mul);

    assign op_b = dec_use_imm ? dec_imm : rs2_data;

    gpr u_gpr (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .we_i    (wb_we),
        .waddr_i (wb_rd),
        .wdata_i (wb_data),
        .raddr1_i(dec_rs1),
        .raddr2_i(dec_rs2),
        .rdata1_o(rs1_data),
        .rdata2_o(rs2_data)
    );

    scoreboard u_scoreboard (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .issue_i  (accept),
        .rs1_i    (dec_rs1),
        .rs2_i    (dec_rs2),
        .rd_i     (dec_rd),
        .use_rs1_i(dec_use_rs1),
        .use_rs2_i(dec_use_rs2),
        .wr_i     (dec_wr),
        .clr_i    (wb_we),
        .clr_rd_i (wb_rd),
        .hazard_o (hazard)
    );

    alu u_alu (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .start_i (alu_start),
        .op_i    (dec_alu_op),
        .a_i     (rs1_data),
        .b_i     (op_b),
        .rd_i    (dec_rd),
        .take_i  (alu_take),
        .valid_o (alu_valid),
        .rd_o    (alu_rd),
        .result_o(alu_result)
    );

    mul_unit u_mul_unit (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .start_i (mul_start),
        .op_i    (dec_mul_op),
        .a_i     (rs1_data),
        .b_i     (rs2_data),
        .rd_i    (dec_rd),
        .take_i  (mul_take),
        .idle_o  (mul_idle),
        .valid_o (mul_valid),
        .rd_o    (mul_rd),
        .result_o(mul_result)
    );

    wb_arbiter u_wb_arbiter (
        .alu_valid_i(alu_valid),
        .alu_rd_i   (alu_rd),
        .alu_data_i (alu_result),
        .mul_valid_i(mul_valid),
        .mul_rd_i   (mul_rd),
        .mul_data_i (mul_result),
        .alu_take_o (alu_take),
        .mul_take_o (mul_take),
        .we_o       (wb_we),
        .rd_o       (wb_rd),
        .data_o     (wb_data)
    );

    // single cycle flag after an illegal word is taken
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            illegal_q <= 1'b0;
        end else begin
            illegal_q <= accept && dec_illegal;
        end
    end

    assign wb_valid_o     = wb_we;
    assign wb_rd_o        = wb_rd;
    assign wb_data_o      = wb_data;
    assign illegal_inst_o = illegal_q;

endmodule

// File: rtl/gpr.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module gpr
    import core_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     we_i,
    input  reg_idx_t waddr_i,
    input  xlen_t    wdata_i,
    input  reg_idx_t raddr1_i,
    input  reg_idx_t raddr2_i,
    output xlen_t    rdata1_o,
    output xlen_t    rdata2_o
);

    xlen_t regs [`REG_NUM];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin  // x0 never written
            regs[waddr_i] <= wdata_i;
        end
    end

    // old value on a same-edge write with no bypass
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// File: rtl/mul_unit.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module mul_unit
    import core_types_pkg::*;
    import core_op_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     start_i,
    input  mul_op_e  op_i,
    input  xlen_t    a_i,
    input  xlen_t    b_i,
    input  reg_idx_t rd_i,
    input  logic     take_i,
    output logic     idle_o,
    output logic     valid_o,
    output reg_idx_t rd_o,
    output xlen_t    result_o
);

    localparam int CNT_W = $clog2(`MUL_STEPS);

    mul_state_e         state_q;
    logic [CNT_W-1:0]   cnt_q;
    mul_op_e            op_q;
    logic               neg_q;       // product sign after magnitude multiply
    logic [2*`XLEN-1:0] prod_q;
    logic [2*`XLEN-1:0] mcand_q;
    xlen_t              mplier_q;
    logic               a_neg;
    logic               b_neg;
    xlen_t              a_mag;
    xlen_t              b_mag;
    logic [2*`XLEN-1:0] prod_fin;

    // mulhu is unsigned on both sides, mulhsu only on rs2
    assign a_neg = (op_i != op_mulhu) && a_i[`XLEN-1];
    assign b_neg = ((op_i == op_mul) || (op_i == op_mulh)) && b_i[`XLEN-1];
    assign a_mag = a_neg ? -a_i : a_i;
    assign b_mag = b_neg ? -b_i : b_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= mul_idle;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                mul_idle: begin
                    if (start_i) begin
                        state_q <= mul_run;
                        cnt_q   <= '0;
                    end
                end
                mul_run: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(`MUL_STEPS - 1)) begin
                        state_q <= mul_done;
                    end
                end
                mul_done: begin
                    if (take_i) state_q <= mul_idle;
                end
                default: state_q <= mul_idle;
            endcase
        end
    end

    // one shift-add step per cycle in run
    always_ff @(posedge clk) begin
        if (start_i && state_q == mul_idle) begin
            op_q     <= op_i;
            rd_o     <= rd_i;
            neg_q    <= a_neg ^ b_neg;
            prod_q   <= '0;
            mcand_q  <= {{`XLEN{1'b0}}, a_mag};
            mplier_q <= b_mag;
        end else if (state_q == mul_run) begin
            if (mplier_q[0]) prod_q <= prod_q + mcand_q;
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign prod_fin = neg_q ? -prod_q : prod_q;

    assign idle_o   = (state_q == mul_idle);
    assign valid_o  = (state_q == mul_done);
    assign result_o = (op_q == op_mul) ? prod_fin[`XLEN-1:0] : prod_fin[2*`XLEN-1:`XLEN];

endmodule

// File: rtl/scoreboard.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module scoreboard
    import core_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     issue_i,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    input  reg_idx_t rd_i,
    input  logic     use_rs1_i,
    input  logic     use_rs2_i,
    input  logic     wr_i,
    input  logic     clr_i,
    input  reg_idx_t clr_rd_i,
    output logic     hazard_o
);

    logic [`REG_NUM-1:0] busy_q;  // one pending write per register
    logic                rs1_busy;
    logic                rs2_busy;
    logic                rd_busy;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q <= '0;
        end else begin
            if (clr_i) begin
                busy_q[clr_rd_i] <= 1'b0;
            end
            // a busy rd stalls issue, so set and clear never hit the same bit
            if (issue_i && wr_i && rd_i != '0) begin
                busy_q[rd_i] <= 1'b1;
            end
        end
    end

    assign rs1_busy = use_rs1_i && busy_q[rs1_i];  // read after write
    assign rs2_busy = use_rs2_i && busy_q[rs2_i];
    assign rd_busy  = wr_i && busy_q[rd_i];        // write after write

    assign hazard_o = rs1_busy || rs2_busy || rd_busy;

endmodule

// File: rtl/wb_arbiter.sv
`timescale 1ns/10ps

module wb_arbiter
    import core_types_pkg::*;
(
    input  logic     alu_valid_i,
    input  reg_idx_t alu_rd_i,
    input  xlen_t    alu_data_i,
    input  logic     mul_valid_i,
    input  reg_idx_t mul_rd_i,
    input  xlen_t    mul_data_i,
    output logic     alu_take_o,
    output logic     mul_take_o,
    output logic     we_o,
    output reg_idx_t rd_o,
    output xlen_t    data_o
);

    // multiply always goes first since it holds only one cycle in done
    assign mul_take_o = mul_valid_i;

    // alu keeps its result when it loses
    assign alu_take_o = alu_valid_i && !mul_valid_i;

    assign we_o = mul_valid_i || alu_valid_i;

    // write port, scoreboard clear and writeback port all see this
    always_comb begin
        if (mul_valid_i) begin
            rd_o   = mul_rd_i;
            data_o = mul_data_i;
        end else begin
            rd_o   = alu_rd_i;
            data_o = alu_data_i;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the exec_core testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_exec_core -f exec_core.f \
    && obj_dir/Vtb_exec_core > sim.log 2>&1 \
    || { echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; } || echo "PASS"

// File: tests/exec_golden.txt
# columns: instruction word, expected rd, expected rd value, illegal flag
# all fields hex, rd 00 means no writeback expected
123450b7 01 12345000 0
ffb00113 02 fffffffb 0
00700193 03 00000007 0
00312233 04 00000001 0
003132b3 05 00000000 0
40115313 06 fffffffd 0
00115393 07 7ffffffd 0
40218433 08 0000000c 0
0ff0c493 09 123450ff 0
00319533 0a 00000380 0
403155b3 0b ffffffff 0
0030e633 0c 12345007 0
0024f6b3 0d 123450fb 0
02310733 0e ffffffdd 0
00118793 0f 00000008 0
02111833 10 ffffffff 0
022128b3 11 fffffffb 0
02213933 12 fffffff6 0
06470993 13 00000041 0
01398a33 14 00000082 0
004a1a93 15 00000820 0
414a8b33 16 0000079e 0
0230cbb3 00 00000000 1
00012083 00 00000000 1
00518013 00 00000000 0
00300c33 18 00000007 0
00008cb3 19 12345000 0
40319d33 00 00000000 1
02840db3 1b 00000090 0
fffffe37 1c fffff000 0
01cd8eb3 1d fffff090 0

// File: tests/tb_exec_core.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module tb_exec_core
    import core_types_pkg::*;
();

    logic     clk;
    logic     rst_n;
    logic     inst_valid;
    inst_t    inst;
    logic     inst_ready;
    logic     wb_valid;
    reg_idx_t wb_rd;
    xlen_t    wb_data;
    logic     illegal_inst;

    // golden lines, one entry per instruction
    inst_t    gold_inst [$];
    reg_idx_t gold_rd [$];
    xlen_t    gold_val [$];
    logic     gold_ill [$];

    // writes still owed by the DUT
    reg_idx_t pend_rd [$];
    xlen_t    pend_val [$];

    int       cur_idx;
    int       accept_cnt;
    int       illegal_exp;
    int       illegal_seen;
    int       mismatch_errs;
    int       other_errs;
    int       cycle_limit = 0;
    logic     alu_due;      // alu result expected on the next edge
    reg_idx_t alu_due_rd;
    logic     mul_busy;
    reg_idx_t mul_rd;
    logic [15:0] lfsr;

    exec_core i_dut (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .inst_valid_i  (inst_valid),
        .inst_i        (inst),
        .inst_ready_o  (inst_ready),
        .wb_valid_o    (wb_valid),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data),
        .illegal_inst_o(illegal_inst)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois form with taps 16/14/13/11
    function automatic logic next_rand_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) lfsr = lfsr ^ 16'hB400;
        return b;
    endfunction

    task automatic check_reg_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (exp !== act) begin
            mismatch_errs++;
            $display("mismatch at %0t: %s expected x%0d got x%0d", $time, name, exp, act);
        end
    endtask

    task automatic check_data(input string name, input xlen_t exp, input xlen_t act);
        if (exp !== act) begin
            mismatch_errs++;
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic load_golden();
        int       fd;
        int       n;
        int       ch;
        inst_t    w;
        reg_idx_t r;
        xlen_t    v;
        logic     il;
        fd = $fopen("tests/exec_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/exec_golden.txt");
            return;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%h %h %h %h", w, r, v, il);
            if (n == 4) begin
                gold_inst.push_back(w);
                gold_rd.push_back(r);
                gold_val.push_back(v);
                gold_ill.push_back(il);
            end else if (n < 0) begin
                break;
            end else begin
                ch = $fgetc(fd);  // skip the rest of a comment line
                while (ch != 10 && ch != -1) ch = $fgetc(fd);
            end
        end
        $fclose(fd);
    endtask

    // alu answers one cycle after issue unless a multiply takes that slot
    task automatic check_alu_slot();
        if (!wb_valid) begin
            other_errs++;
            $display("%0t: no writeback for ALU result to x%0d", $time, alu_due_rd);
            alu_due = 1'b0;
        end else if (!(mul_busy && wb_rd == mul_rd)) begin
            check_reg_idx("wb_rd_o", alu_due_rd, wb_rd);
            alu_due = 1'b0;
        end
    endtask

    task automatic match_writeback(input reg_idx_t rd, input xlen_t data);
        int hit;
        hit = -1;
        for (int i = 0; i < pend_rd.size(); i++) begin
            if (pend_rd[i] == rd) hit = i;  // scoreboard allows one per rd
        end
        if (hit < 0) begin
            other_errs++;
            $display("%0t: writeback to x%0d that no instruction asked for", $time, rd);
        end else begin
            check_data("wb_data_o", pend_val[hit], data);
            pend_rd.delete(hit);
            pend_val.delete(hit);
            if (mul_busy && rd == mul_rd) mul_busy = 1'b0;
        end
    endtask

    task automatic record_accept(input int idx);
        inst_t w;
        logic  is_mul;
        w = gold_inst[idx];
        is_mul = (w[6:0] == `OPC_OP) && (w[31:25] == `F7_MULDIV);
        accept_cnt++;
        if (gold_ill[idx]) illegal_exp++;
        if (!gold_ill[idx] && gold_rd[idx] != '0) begin
            pend_rd.push_back(gold_rd[idx]);
            pend_val.push_back(gold_val[idx]);
            if (is_mul) begin
                if (mul_busy) begin
                    other_errs++;
                    $display("%0t: second multiply accepted while one is running", $time);
                end
                mul_busy = 1'b1;
                mul_rd   = gold_rd[idx];
            end else begin
                alu_due    = 1'b1;
                alu_due_rd = gold_rd[idx];
            end
        end
    endtask

    // values seen here are the ones held through the cycle before the edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (illegal_inst) illegal_seen++;
            if (alu_due) check_alu_slot();
            if (wb_valid) match_writeback(wb_rd, wb_data);
            if (inst_valid && inst_ready) record_accept(cur_idx);
        end
    end

    task automatic send_inst(input int idx);
        int gap;
        gap = 0;
        if (next_rand_bit()) gap += 2;
        if (next_rand_bit()) gap += 1;
        repeat (gap) @(negedge clk);
        cur_idx    = idx;
        inst       = gold_inst[idx];
        inst_valid = 1'b1;
        @(negedge clk);
        while (accept_cnt <= idx) @(negedge clk);  // hold until taken
        inst_valid = 1'b0;
    endtask

    initial begin
        for (int n = 0; n < cycle_limit || cycle_limit == 0; n++) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("tests failed");
        $finish;
    end

    initial begin
        rst_n         = 1'b0;
        inst_valid    = 1'b0;
        inst          = '0;
        cur_idx       = 0;
        accept_cnt    = 0;
        illegal_exp   = 0;
        illegal_seen  = 0;
        mismatch_errs = 0;
        other_errs    = 0;
        alu_due       = 1'b0;
        alu_due_rd    = '0;
        mul_busy      = 1'b0;
        mul_rd        = '0;
        lfsr          = 16'd47974;
        load_golden();
        cycle_limit = gold_inst.size() * (`MUL_STEPS + 8) + 100;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        if (gold_inst.size() == 0) begin
            other_errs++;
            $display("no instructions found in the golden file");
        end else begin
            for (int i = 0; i < gold_inst.size(); i++) begin
                send_inst(i);
            end
            while (pend_rd.size() != 0) @(negedge clk);
            repeat (4) @(negedge clk);  // catch late stray writebacks
        end
        if (illegal_seen != illegal_exp) begin
            other_errs++;
            $display("illegal_inst_o pulsed %0d times, %0d illegal words were sent",
                     illegal_seen, illegal_exp);
        end
        $display("errors: %0d value mismatches, %0d other failures", mismatch_errs, other_errs);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
